/* eye_tracker_top.f */
cl_pkg.sv
grav_pkg.sv
cam_input.sv
gravity_accum.sv
sums_packetizer.sv
uart_tx.sv
eye_tracker_top.sv
tb_eye_tracker.sv

/* Bender.yml */
package:
  name: eye_tracker_top

sources:
  - cl_pkg.sv
  - grav_pkg.sv
  - cam_input.sv
  - gravity_accum.sv
  - sums_packetizer.sv
  - uart_tx.sv
  - eye_tracker_top.sv
  - target: simulation
    files:
      - tb_eye_tracker.sv

/* tb_eye_tracker.sv */
// Testbench for the eye tracker measurement path
// Generates random Camera Link frames, models the dark pixel sums,
// decodes the UART packets and compares them byte by byte.
// Also covers bright and dark frames and a frame dropped under back-pressure
`timescale 1ns/10ps
`default_nettype none

module tb_eye_tracker;
    import cl_pkg::*;
    import grav_pkg::*;

    localparam int tb_clks_per_bit   = 16;
    localparam int bit_ns            = tb_clks_per_bit * 10;
    localparam int packet_cycles     = packet_bytes * uart_frame_bits * tb_clks_per_bit;
    localparam int max_beats         = 40;
    localparam int max_lines         = 30;
    localparam int max_beat_gap      = 3;
    localparam int max_line_blank    = 6;
    localparam int longest_frame     = max_lines * (max_beats * (1 + max_beat_gap)
                                       + max_line_blank) + 8;
    localparam int frame_gap_cycles  = packet_cycles + 64;  // Wider than one packet
    localparam int num_random_frames = 8;
    localparam int num_frames        = num_random_frames + 5;
    localparam int watchdog_cycles   = num_frames * (longest_frame + packet_cycles) * 2;

    logic   cclk;
    logic   arst_n;
    logic   fval;
    logic   lval;
    logic   dval;
    pixel_t data_l;
    pixel_t data_r;
    pixel_t threshold;
    logic   uart_txd;
    byte_t  exp_q[$];  // Expected packet bytes in line order

    eye_tracker_top #(
        .clks_per_bit (tb_clks_per_bit)
    ) i_eye_tracker_top (
        .cclk      (cclk),
        .arst_n    (arst_n),
        .fval      (fval),
        .lval      (lval),
        .dval      (dval),
        .data_l    (data_l),
        .data_r    (data_r),
        .threshold (threshold),
        .uart_txd  (uart_txd)
    );

    initial cclk = 1'b0;
    always #5 cclk = ~cclk;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic next_cycle();
        @(posedge cclk);
        #1;
    endtask

    // Line valid low, random data and data valid that must be ignored
    task automatic drive_blank(input logic in_frame, input int cycles);
        repeat (cycles) begin
            next_cycle();
            fval   = in_frame;
            lval   = 1'b0;
            dval   = 1'($urandom_range(1, 0));
            data_l = pixel_t'($urandom_range(255, 0));
            data_r = pixel_t'($urandom_range(255, 0));
        end
    endtask

    // ----------------------------------------
    // Reference packet
    // ----------------------------------------
    task automatic push_packet(input int unsigned s, input int unsigned sx,
                               input int unsigned sy);
        int unsigned s_w;
        int unsigned sx_w;
        int unsigned sy_w;
        s_w  = s & ((32'd1 << sum_s_width) - 1);
        sx_w = sx & ((32'd1 << sum_sx_width) - 1);
        sy_w = sy & ((32'd1 << sum_sy_width) - 1);
        exp_q.push_back(packet_sync);
        for (int i = sum_s_bytes - 1; i >= 0; i--) exp_q.push_back(byte_t'(s_w >> (8 * i)));
        for (int i = sum_sx_bytes - 1; i >= 0; i--) exp_q.push_back(byte_t'(sx_w >> (8 * i)));
        for (int i = sum_sy_bytes - 1; i >= 0; i--) exp_q.push_back(byte_t'(sy_w >> (8 * i)));
    endtask

    function automatic pixel_t pick_pixel(input int mode);
        case (mode)
            1:       return 8'hFF;  // Bright
            2:       return 8'h00;  // Dark
            default: return pixel_t'($urandom_range(255, 0));
        endcase
    endfunction

    // Mode 0 random, 1 all bright, 2 all dark
    task automatic drive_frame(input int beats, input int lines, input int mode,
                               input bit expect_pkt, input int gap_after);
        int unsigned s;
        int unsigned sx;
        int unsigned sy;
        int          thr;
        pixel_t      pl;
        pixel_t      pr;
        s   = 0;
        sx  = 0;
        sy  = 0;
        thr = (mode == 2) ? $urandom_range(255, 1) : $urandom_range(255, 0);
        threshold = pixel_t'(thr);  // Changes only between frames
        drive_blank(1'b1, $urandom_range(4, 2));
        for (int y = 0; y < lines; y++) begin
            for (int k = 0; k < beats; k++) begin
                if ($urandom_range(3, 0) == 0) begin
                    repeat ($urandom_range(max_beat_gap, 1)) begin
                        next_cycle();
                        fval   = 1'b1;
                        lval   = 1'b1;
                        dval   = 1'b1;   // Invalid, dark data must not count
                        data_l = 8'h00;
                        data_r = 8'h00;
                    end
                end
                pl = pick_pixel(mode);
                pr = pick_pixel(mode);
                next_cycle();
                fval   = 1'b1;
                lval   = 1'b1;
                dval   = 1'b0;
                data_l = pl;
                data_r = pr;
                if (int'(pl) < thr) begin
                    s  += 1;
                    sx += 2 * k;
                    sy += y;
                end
                if (int'(pr) < thr) begin
                    s  += 1;
                    sx += 2 * k + 1;
                    sy += y;
                end
            end
            drive_blank(1'b1, $urandom_range(max_line_blank, 2));
        end
        drive_blank(1'b0, 1);
        if (expect_pkt) begin
            if (mode == 1) begin
                push_packet(0, 0, 0);
            end else if (mode == 2) begin
                push_packet(2 * beats * lines, lines * beats * (2 * beats - 1),
                            beats * lines * (lines - 1));
            end else begin
                push_packet(s, sx, sy);
            end
        end
        drive_blank(1'b0, gap_after);
    endtask

    // ----------------------------------------
    // UART decoder, samples mid-bit
    // ----------------------------------------
    initial begin : uart_decoder
        byte_t rx;
        byte_t want;
        wait (arst_n === 1'b1);
        forever begin
            @(negedge uart_txd);
            #(bit_ns / 2 + 3);  // Clear of the clock edge
            assert (uart_txd === 1'b0)
                else stop_with_error("Start bit on uart_txd was shorter than half a bit");
            for (int i = 0; i < byte_width; i++) begin
                #(bit_ns);
                rx[i] = uart_txd;
            end
            assert (exp_q.size() != 0)
                else stop_with_error("A byte arrived on uart_txd when no packet was expected");
            want = exp_q.pop_front();
            assert (rx === want)
                else stop_with_error($sformatf("ERR %0t: byte %02h received, %02h expected",
                                               $time, rx, want));
            #(bit_ns);
            assert (uart_txd === 1'b1)
                else stop_with_error("Framing error, the stop bit on uart_txd was low");
        end
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge cclk);
        $display("Timeout, the run did not finish within %0d clock cycles", watchdog_cycles);
        $display("Some tests failed");
        $fatal(1);
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin : stimulus
        void'($urandom(65));
        arst_n    = 1'b0;
        fval      = 1'b0;
        lval      = 1'b0;
        dval      = 1'b1;
        data_l    = '0;
        data_r    = '0;
        threshold = '0;
        repeat (16) @(posedge cclk);
        #1 arst_n = 1'b1;

        repeat (200) begin  // No frames yet, line must stay idle
            next_cycle();
            assert (uart_txd === 1'b1)
                else stop_with_error($sformatf("ERR %0t: uart_txd not idle high", $time));
        end

        for (int n = 0; n < num_random_frames; n++) begin
            drive_frame($urandom_range(max_beats, 4), $urandom_range(max_lines, 3),
                        0, 1'b1, frame_gap_cycles);
        end
        drive_frame($urandom_range(max_beats, 4), $urandom_range(max_lines, 3),
                    1, 1'b1, frame_gap_cycles);
        drive_frame($urandom_range(max_beats, 4), $urandom_range(max_lines, 3),
                    2, 1'b1, frame_gap_cycles);

        // Second frame ends during the first packet and is dropped
        drive_frame($urandom_range(max_beats, 4), $urandom_range(max_lines, 3),
                    0, 1'b1, 5);
        drive_frame(4, 3, 0, 1'b0, frame_gap_cycles);
        drive_frame($urandom_range(max_beats, 4), $urandom_range(max_lines, 3),
                    0, 1'b1, frame_gap_cycles);

        wait (exp_q.size() == 0);
        #(bit_ns * 2);  // Last stop bit
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* eye_tracker_top.sv */
// Eye tracker measurement path
// Camera Link input, dark pixel centre of gravity over each frame,
// and the per-frame sums sent as a 12-byte UART packet.
// Single clock domain on the camera clock
`timescale 1ns/10ps
`default_nettype none

module eye_tracker_top #(
    parameter int clks_per_bit = grav_pkg::default_clks_per_bit
) (
    input  logic           cclk,
    input  logic           arst_n,
    input  logic           fval,
    input  logic           lval,
    input  logic           dval,
    input  cl_pkg::pixel_t data_l,
    input  cl_pkg::pixel_t data_r,
    input  cl_pkg::pixel_t threshold,  // Board jumpers
    output logic           uart_txd
);
    import cl_pkg::*;
    import grav_pkg::*;

    cam_beat_t  beat;
    grav_sums_t sums;
    logic       frame_done;
    logic       pkt_busy;
    logic       tx_start;
    logic       tx_busy;
    byte_t      tx_byte;

    // ----------------------------------------
    // Video side
    // ----------------------------------------
    cam_input i_cam_input (
        .cclk   (cclk),
        .arst_n (arst_n),
        .fval   (fval),
        .lval   (lval),
        .dval   (dval),
        .data_l (data_l),
        .data_r (data_r),
        .beat   (beat)
    );

    gravity_accum i_gravity_accum (
        .cclk       (cclk),
        .arst_n     (arst_n),
        .beat       (beat),
        .threshold  (threshold),
        .pkt_busy   (pkt_busy),
        .sums       (sums),
        .frame_done (frame_done)
    );

    // ----------------------------------------
    // Report side
    // ----------------------------------------
    sums_packetizer i_sums_packetizer (
        .cclk       (cclk),
        .arst_n     (arst_n),
        .sums       (sums),
        .frame_done (frame_done),
        .tx_busy    (tx_busy),
        .tx_start   (tx_start),
        .tx_byte    (tx_byte),
        .pkt_busy   (pkt_busy)
    );

    uart_tx #(
        .clks_per_bit (clks_per_bit)
    ) i_uart_tx (
        .cclk     (cclk),
        .arst_n   (arst_n),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx_busy  (tx_busy),
        .txd      (uart_txd)
    );

endmodule

`default_nettype wire

/* uart_tx.sv */
// UART transmitter, 8N1
// Start bit, eight data bits LSB first, one stop bit.
// Bit period set by clks_per_bit camera clocks
`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
    parameter int clks_per_bit = grav_pkg::default_clks_per_bit
) (
    input  logic            cclk,
    input  logic            arst_n,
    input  logic            tx_start,
    input  grav_pkg::byte_t tx_byte,
    output logic            tx_busy,
    output logic            txd
);
    import grav_pkg::*;

    logic [$clog2(clks_per_bit)-1:0] bit_cnt;
    logic [uart_idx_width-1:0]       bit_idx;   // 0 is the start bit
    logic [byte_width:0]             shreg;     // Data plus stop bit
    logic                            bit_end;

    assign bit_end = (bit_cnt == $bits(bit_cnt)'(clks_per_bit - 1));

    // ----------------------------------------
    // Bit timing and line
    // ----------------------------------------
    always_ff @(posedge cclk or negedge arst_n) begin
        if (!arst_n) begin
            tx_busy <= 1'b0;
            txd     <= 1'b1;  // Idle high
            bit_cnt <= '0;
            bit_idx <= '0;
        end else if (!tx_busy) begin
            bit_cnt <= '0;
            bit_idx <= '0;
            if (tx_start) begin
                tx_busy <= 1'b1;
                txd     <= 1'b0;  // Start bit
            end
        end else if (bit_end) begin
            bit_cnt <= '0;
            if (bit_idx == uart_idx_width'(uart_frame_bits - 1)) begin
                tx_busy <= 1'b0;  // End of stop bit
                txd     <= 1'b1;
            end else begin
                bit_idx <= bit_idx + 1'b1;
                txd     <= shreg[0];
            end
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Shift register, refilled with ones behind the data
    always_ff @(posedge cclk) begin
        if (!tx_busy && tx_start) begin
            shreg <= {1'b1, tx_byte};
        end else if (tx_busy && bit_end) begin
            shreg <= {1'b1, shreg[byte_width:1]};
        end
    end

    a_no_start_busy : assert property (@(posedge cclk) disable iff (!arst_n)
        tx_start |-> !tx_busy)
        else $error("tx_start while transmitter busy");

endmodule

`default_nettype wire

/* sums_packetizer.sv */
// Result packetizer
// Sends sync byte, S (3 bytes), SX (4 bytes) and SY (4 bytes),
// each sum zero-extended and most significant byte first.
// One byte per transmitter frame
`timescale 1ns/10ps
`default_nettype none

module sums_packetizer (
    input  logic                 cclk,
    input  logic                 arst_n,
    input  grav_pkg::grav_sums_t sums,
    input  logic                 frame_done,
    input  logic                 tx_busy,
    output logic                 tx_start,
    output grav_pkg::byte_t      tx_byte,
    output logic                 pkt_busy
);
    import grav_pkg::*;

    typedef enum logic [1:0] {
        st_idle,  // Waiting for a frame result
        st_load,  // Strobe one byte into the UART
        st_wait   // Byte on the line
    } state_t;

    state_t                         state;
    logic [pkt_idx_width-1:0]       byte_idx;
    logic [packet_bytes*byte_width-1:0] pkt_word;

    // Whole packet, sync byte on top
    assign pkt_word = {packet_sync,
                       {(sum_s_bytes*byte_width-sum_s_width){1'b0}},   sums.sum_s,
                       {(sum_sx_bytes*byte_width-sum_sx_width){1'b0}}, sums.sum_sx,
                       {(sum_sy_bytes*byte_width-sum_sy_width){1'b0}}, sums.sum_sy};

    assign tx_byte  = pkt_word[byte_width*(packet_bytes-1-byte_idx) +: byte_width];
    assign tx_start = (state == st_load);
    assign pkt_busy = (state != st_idle);

    always_ff @(posedge cclk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            byte_idx <= '0;
        end else begin
            case (state)
                st_idle: begin
                    byte_idx <= '0;
                    if (frame_done) begin
                        state <= st_load;
                    end
                end
                st_load: begin
                    state <= st_wait;  // UART raises tx_busy next cycle
                end
                st_wait: begin
                    if (!tx_busy) begin  // Stop bit finished
                        if (byte_idx == pkt_idx_width'(packet_bytes - 1)) begin
                            state <= st_idle;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                            state    <= st_load;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* gravity_accum.sv */
// Centre of gravity accumulator
// Tracks column and row of each tap, marks pixels below threshold
// as pupil and sums their count, columns and rows over a frame.
// The totals are latched and announced when the frame ends,
// unless the previous packet is still going out
`timescale 1ns/10ps
`default_nettype none

module gravity_accum (
    input  logic                 cclk,
    input  logic                 arst_n,
    input  cl_pkg::cam_beat_t    beat,
    input  cl_pkg::pixel_t       threshold,
    input  logic                 pkt_busy,
    output grav_pkg::grav_sums_t sums,
    output logic                 frame_done
);
    import cl_pkg::*;
    import grav_pkg::*;

    logic                    vsync_d;
    logic                    hsync_d;
    logic                    vsync_rise;
    logic                    vsync_fall;
    logic                    line_end;
    logic                    take;
    logic [coord_width-1:0]  col;       // Column of the left tap
    logic [coord_width-1:0]  col_r;
    logic [coord_width-1:0]  row;
    logic                    dark_l;
    logic                    dark_r;
    logic [1:0]              add_s;
    logic [coord_width:0]    add_sx;
    logic [coord_width:0]    add_sy;
    logic [sum_s_width-1:0]  acc_s;
    logic [sum_sx_width-1:0] acc_sx;
    logic [sum_sy_width-1:0] acc_sy;

    assign vsync_rise = beat.vsync & ~vsync_d;
    assign vsync_fall = ~beat.vsync & vsync_d;
    assign line_end   = ~beat.hsync & hsync_d;
    assign take       = vsync_fall & ~pkt_busy;  // Dropped while a packet is out

    // ----------------------------------------
    // Per-beat contribution
    // ----------------------------------------
    assign col_r  = {col[coord_width-1:1], 1'b1};  // col is always even
    assign dark_l = beat.de && (beat.data_l < threshold);
    assign dark_r = beat.de && (beat.data_r < threshold);

    assign add_s  = {1'b0, dark_l} + {1'b0, dark_r};
    assign add_sx = (dark_l ? {1'b0, col} : '0) + (dark_r ? {1'b0, col_r} : '0);
    assign add_sy = (dark_l ? {1'b0, row} : '0) + (dark_r ? {1'b0, row} : '0);

    // ----------------------------------------
    // Position counters
    // ----------------------------------------
    always_ff @(posedge cclk or negedge arst_n) begin
        if (!arst_n) begin
            vsync_d    <= 1'b0;
            hsync_d    <= 1'b0;
            col        <= '0;
            row        <= '0;
            frame_done <= 1'b0;
        end else begin
            vsync_d    <= beat.vsync;
            hsync_d    <= beat.hsync;
            frame_done <= take;

            if (!beat.hsync) begin
                col <= '0;
            end else if (beat.de) begin
                col <= col + coord_width'(2);  // Two taps per beat
            end

            if (!beat.vsync) begin
                row <= '0;
            end else if (line_end) begin
                row <= row + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Sums
    // ----------------------------------------
    always_ff @(posedge cclk) begin
        if (vsync_rise) begin  // New frame
            acc_s  <= sum_s_width'(add_s);
            acc_sx <= sum_sx_width'(add_sx);
            acc_sy <= sum_sy_width'(add_sy);
        end else begin
            acc_s  <= acc_s + sum_s_width'(add_s);
            acc_sx <= acc_sx + sum_sx_width'(add_sx);
            acc_sy <= acc_sy + sum_sy_width'(add_sy);
        end

        if (take) begin
            sums <= '{sum_s: acc_s, sum_sx: acc_sx, sum_sy: acc_sy};
        end
    end

    // The 32-bit sum shows a wrap as a mismatch
    a_col_no_wrap : assert property (@(posedge cclk) disable iff (!arst_n)
        beat.de |=> col == $past(col) + 2)
        else $error("column counter wrapped, line too long");

endmodule

`default_nettype wire

/* cam_input.sv */
// Camera Link input stage
// Registers the raw pins once and converts FVAL, LVAL and DVAL
// to active-high flags. A beat is valid only inside frame and line
`timescale 1ns/10ps
`default_nettype none

module cam_input (
    input  logic              cclk,
    input  logic              arst_n,
    input  logic              fval,
    input  logic              lval,
    input  logic              dval,
    input  cl_pkg::pixel_t    data_l,
    input  cl_pkg::pixel_t    data_r,
    output cl_pkg::cam_beat_t beat
);
    import cl_pkg::*;

    logic   frame_act;
    logic   line_act;
    logic   data_act;
    logic   vsync_q;
    logic   hsync_q;
    logic   de_q;
    pixel_t data_l_q;
    pixel_t data_r_q;

    assign frame_act = (fval == fval_active_high);
    assign line_act  = (lval == lval_active_high);
    assign data_act  = (dval == dval_active_high);

    // Sync flags
    always_ff @(posedge cclk or negedge arst_n) begin
        if (!arst_n) begin
            vsync_q <= 1'b0;
            hsync_q <= 1'b0;
            de_q    <= 1'b0;
        end else begin
            vsync_q <= frame_act;
            hsync_q <= line_act;
            de_q    <= frame_act & line_act & data_act;
        end
    end

    // Pixel taps
    always_ff @(posedge cclk) begin
        data_l_q <= data_l;
        data_r_q <= data_r;
    end

    assign beat = '{vsync: vsync_q, hsync: hsync_q, de: de_q,
                    data_l: data_l_q, data_r: data_r_q};

    // Camera must keep LVAL inside FVAL
    a_line_in_frame : assert property (@(posedge cclk) disable iff (!arst_n)
        beat.hsync |-> beat.vsync)
        else $error("line valid seen outside frame valid");

endmodule

`default_nettype wire

/* grav_pkg.sv */
// Pupil centre of gravity and its report packet
// Sum widths, the sums struct, packet layout and UART framing
`default_nettype none

package grav_pkg;

    // ----------------------------------------
    // Accumulator widths
    // ----------------------------------------
    localparam int sum_s_width  = 20;
    localparam int sum_sx_width = 28;
    localparam int sum_sy_width = 28;

    typedef struct packed {
        logic [sum_s_width-1:0]  sum_s;   // Dark pixel count
        logic [sum_sx_width-1:0] sum_sx;  // Sum of columns
        logic [sum_sy_width-1:0] sum_sy;  // Sum of rows
    } grav_sums_t;

    // ----------------------------------------
    // Packet and UART
    // ----------------------------------------
    localparam int byte_width = 8;
    typedef logic [byte_width-1:0] byte_t;

    localparam byte_t packet_sync  = 8'hA5;
    localparam int    sum_s_bytes  = 3;
    localparam int    sum_sx_bytes = 4;
    localparam int    sum_sy_bytes = 4;
    localparam int    packet_bytes = 1 + sum_s_bytes + sum_sx_bytes + sum_sy_bytes;
    localparam int    pkt_idx_width = $clog2(packet_bytes);

    localparam int uart_frame_bits      = 10;  // Start, 8 data, stop
    localparam int uart_idx_width       = $clog2(uart_frame_bits);
    localparam int default_clks_per_bit = 369; // 85 MHz to 230400 bd

endpackage

`default_nettype wire

/* cl_pkg.sv */
// Camera Link side definitions
// Base configuration with two 8-bit taps per beat, plus the
// sync polarities that the camera drives on its pins
`default_nettype none

package cl_pkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------
    localparam int pixel_width = 8;   // Bits per tap
    localparam int coord_width = 11;  // Column and row counters

    // ----------------------------------------
    // Pin polarities
    // ----------------------------------------
    localparam logic fval_active_high = 1'b1;
    localparam logic lval_active_high = 1'b1;
    localparam logic dval_active_high = 1'b0;  // Camera pulls DVAL low for valid data

    typedef logic [pixel_width-1:0] pixel_t;

    // One registered beat, flags already at active level
    typedef struct packed {
        logic   vsync;   // In frame
        logic   hsync;   // In line
        logic   de;      // Valid beat
        pixel_t data_l;  // Even column
        pixel_t data_r;  // Odd column
    } cam_beat_t;

endpackage

`default_nettype wire
